// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: build
	$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== flist.f ====
+incdir+tb
rtl/rv_core_pkg.sv
rtl/control_fsm.sv
rtl/instr_decoder.sv
rtl/exec_unit.sv
rtl/reg_file.sv
rtl/fetch_unit.sv
rtl/lsu.sv
rtl/mem_arbiter.sv
rtl/rv_core_top.sv
tb/tb_core.sv

// ==== rtl/control_fsm.sv ====
`timescale 1ns/1ps

module control_fsm import rv_core_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  opcode_e    opcode,
  input  logic [2:0] funct3,
  input  logic       funct7_alt,
  input  logic       branch_taken,
  input  logic       fetch_done,
  input  logic       lsu_done,
  output logic       fetch_start,
  output logic       load_start,
  output logic       store_start,
  output alu_op_e    alu_op,
  output op_a_sel_e  op_a_sel,
  output op_b_sel_e  op_b_sel,
  output wb_sel_e    wb_sel,
  output logic       reg_we,
  output logic       pc_we,
  output logic       halt
);

  typedef enum logic [3:0] {
    s_fetch,         // Strobe fetch_start
    s_wait_fetch,    // Wait for the instruction register
    s_decode,        // Dispatch on opcode
    s_exec_reg,      // rd <- rs1 op rs2
    s_exec_imm,      // rd <- rs1 op imm
    s_lui,           // rd <- imm
    s_auipc,         // rd <- pc + imm
    s_branch,        // Compare rs1 and rs2
    s_branch_taken,  // pc <- pc + imm
    s_link,          // rd <- pc + 4
    s_jump,          // pc <- pc + imm, or rs1 + imm for JALR
    s_mem_addr,      // rs1 + imm into the LSU
    s_mem_wait,      // Memory round trip
    s_load_wb,       // rd <- load data
    s_pc_adv,        // pc <- pc + 4
    s_halt
  } state_e;

  state_e  state, next_state;
  alu_op_e alu_fn;  // ALU operation of the current ALU instruction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= s_fetch;  // First fetch_start right after reset
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;  // Wait states hold by default
    case (state)
      s_fetch:      next_state = s_wait_fetch;
      s_wait_fetch: if (fetch_done) next_state = s_decode;
      s_decode: begin
        case (opcode)
          op_lui:              next_state = s_lui;
          op_auipc:            next_state = s_auipc;
          op_jal, op_jalr:     next_state = s_link;
          op_branch:           next_state = s_branch;
          op_load, op_store:   next_state = s_mem_addr;
          op_imm:              next_state = s_exec_imm;
          op_reg:              next_state = s_exec_reg;
          default:             next_state = s_halt;  // FENCE, SYSTEM and unknown codes
        endcase
      end
      s_exec_reg, s_exec_imm, s_lui, s_auipc: next_state = s_pc_adv;
      s_branch:       next_state = branch_taken ? s_branch_taken : s_pc_adv;
      s_link:         next_state = s_jump;
      s_mem_addr:     next_state = s_mem_wait;
      s_mem_wait: begin
        if (lsu_done) begin
          next_state = (opcode == op_load) ? s_load_wb : s_pc_adv;  // Stores skip writeback
        end
      end
      s_load_wb:      next_state = s_pc_adv;
      s_branch_taken, s_jump, s_pc_adv: next_state = s_fetch;
      default:        next_state = s_halt;  // s_halt is final
    endcase
  end

  // funct3 to ALU op; alt bit means sub for R-type only, sra for either form
  always_comb begin
    case (funct3)
      3'b000:  alu_fn = (funct7_alt && state == s_exec_reg) ? alu_sub : alu_add;
      3'b001:  alu_fn = alu_sll;
      3'b010:  alu_fn = alu_slt;
      3'b011:  alu_fn = alu_sltu;
      3'b100:  alu_fn = alu_xor;
      3'b101:  alu_fn = funct7_alt ? alu_sra : alu_srl;
      3'b110:  alu_fn = alu_or;
      default: alu_fn = alu_and;
    endcase
  end

  always_comb begin
    fetch_start = 1'b0;
    load_start  = 1'b0;
    store_start = 1'b0;
    alu_op      = alu_add;
    op_a_sel    = a_rs1;
    op_b_sel    = b_rs2;
    wb_sel      = wb_alu;
    reg_we      = 1'b0;
    pc_we       = 1'b0;
    case (state)
      s_fetch: fetch_start = 1'b1;
      s_exec_reg: begin
        alu_op = alu_fn;
        reg_we = 1'b1;
      end
      s_exec_imm: begin
        alu_op   = alu_fn;
        op_b_sel = b_imm;
        reg_we   = 1'b1;
      end
      s_lui: begin
        alu_op   = alu_pass_b;
        op_b_sel = b_imm;
        reg_we   = 1'b1;
      end
      s_auipc: begin
        op_a_sel = a_pc;
        op_b_sel = b_imm;
        reg_we   = 1'b1;
      end
      s_branch_taken: begin
        op_a_sel = a_pc;
        op_b_sel = b_imm;
        pc_we    = 1'b1;
      end
      s_link: begin
        op_a_sel = a_four;  // Return address pc + 4
        reg_we   = 1'b1;
      end
      s_jump: begin
        op_a_sel = (opcode == op_jalr) ? a_rs1 : a_pc;
        op_b_sel = b_imm;
        pc_we    = 1'b1;
      end
      s_mem_addr: begin
        op_b_sel    = b_imm;  // LSU captures rs1 + imm and rs2 here
        load_start  = (opcode == op_load);
        store_start = (opcode == op_store);
      end
      s_load_wb: begin
        wb_sel = wb_load;
        reg_we = 1'b1;
      end
      s_pc_adv: begin
        op_a_sel = a_four;
        pc_we    = 1'b1;
      end
      default: ;
    endcase
  end

  assign halt = (state == s_halt);

endmodule

// ==== rtl/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit import rv_core_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = 32'h0000_0000
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [xlen-1:0] rs1_val,
  input  logic [xlen-1:0] rs2_val,
  input  logic [xlen-1:0] imm,
  input  logic [2:0]      funct3,
  input  alu_op_e         alu_op,
  input  op_a_sel_e       op_a_sel,
  input  op_b_sel_e       op_b_sel,
  input  wb_sel_e         wb_sel,
  input  logic            pc_we,
  input  logic [xlen-1:0] load_data,
  output logic [xlen-1:0] pc,
  output logic [xlen-1:0] alu_result,
  output logic [xlen-1:0] wb_data,
  output logic            branch_taken
);

  logic [xlen-1:0] op_a, op_b;

  // Bit 0 forced low, only JALR can produce an odd target
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else if (pc_we) begin
      pc <= {alu_result[xlen-1:1], 1'b0};
    end
  end

  always_comb begin
    case (op_a_sel)
      a_pc:    op_a = pc;
      a_four:  op_a = xlen'(4);
      default: op_a = rs1_val;
    endcase
  end

  // With the constant four the PC moves to the b side, giving pc + 4
  assign op_b = (op_a_sel == a_four) ? pc : ((op_b_sel == b_imm) ? imm : rs2_val);

  always_comb begin
    case (alu_op)
      alu_sub:    alu_result = op_a - op_b;
      alu_sll:    alu_result = op_a << op_b[4:0];
      alu_slt:    alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:    alu_result = op_a ^ op_b;
      alu_srl:    alu_result = op_a >> op_b[4:0];
      alu_sra:    alu_result = $signed(op_a) >>> op_b[4:0];
      alu_or:     alu_result = op_a | op_b;
      alu_and:    alu_result = op_a & op_b;
      alu_pass_b: alu_result = op_b;
      default:    alu_result = op_a + op_b;  // alu_add
    endcase
  end

  // Compare always on the register values
  always_comb begin
    case (funct3)
      f3_beq:  branch_taken = (rs1_val == rs2_val);
      f3_bne:  branch_taken = (rs1_val != rs2_val);
      f3_blt:  branch_taken = ($signed(rs1_val) < $signed(rs2_val));
      f3_bge:  branch_taken = ($signed(rs1_val) >= $signed(rs2_val));
      f3_bltu: branch_taken = (rs1_val < rs2_val);
      f3_bgeu: branch_taken = (rs1_val >= rs2_val);
      default: branch_taken = 1'b0;  // Reserved codes never branch
    endcase
  end

  assign wb_data = (wb_sel == wb_load) ? load_data : alu_result;

endmodule

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import rv_core_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            fetch_start,
  input  logic [xlen-1:0] pc,
  output logic            fetch_mem_req,
  output logic [xlen-1:0] fetch_addr,
  input  logic            fetch_mem_resp,
  input  logic [xlen-1:0] mem_rdata,
  output logic [xlen-1:0] instr,
  output logic            fetch_done
);

  logic busy;  // Fetch outstanding

  // Request goes out with the strobe, the arbiter latches pc as the address
  assign fetch_mem_req = fetch_start;
  assign fetch_addr    = pc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      fetch_done <= 1'b0;
    end else begin
      fetch_done <= busy & fetch_mem_resp;  // One cycle after the response
      if (fetch_start) begin
        busy <= 1'b1;
      end else if (fetch_mem_resp) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (busy && fetch_mem_resp) begin
      instr <= mem_rdata;
    end
  end

endmodule

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder import rv_core_pkg::*; (
  input  logic [xlen-1:0]       instr,
  output opcode_e               opcode,
  output logic [reg_addr_w-1:0] rd,
  output logic [reg_addr_w-1:0] rs1,
  output logic [reg_addr_w-1:0] rs2,
  output logic [2:0]            funct3,
  output logic                  funct7_alt,
  output logic [xlen-1:0]       imm
);

  assign rd         = instr[11:7];
  assign rs1        = instr[19:15];
  assign rs2        = instr[24:20];
  assign funct3     = instr[14:12];
  assign funct7_alt = instr[30];  // sub / sra select

  always_comb begin
    case (instr[6:0])
      op_lui, op_auipc, op_jal, op_jalr, op_branch,
      op_load, op_store, op_imm, op_reg, op_fence: begin
        opcode = opcode_e'(instr[6:0]);
      end
      default: opcode = op_system;  // Anything unknown ends in halt
    endcase
  end

  // Immediate by format, sign bit always instr[31]
  always_comb begin
    case (opcode)
      op_store:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};                // S
      op_branch: begin
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};  // B
      end
      op_lui, op_auipc: imm = {instr[31:12], 12'b0};                                 // U
      op_jal: begin
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};  // J
      end
      default:   imm = {{20{instr[31]}}, instr[31:20]};  // I: op_imm, load, jalr
    endcase
  end

endmodule

// ==== rtl/lsu.sv ====
`timescale 1ns/1ps

module lsu import rv_core_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            load_start,
  input  logic            store_start,
  input  logic [xlen-1:0] addr,
  input  logic [xlen-1:0] store_data,
  output logic            lsu_mem_req,
  output logic            lsu_mem_we,
  output logic [xlen-1:0] lsu_addr,
  output logic [xlen-1:0] lsu_wdata,
  input  logic            lsu_mem_resp,
  input  logic [xlen-1:0] mem_rdata,
  output logic [xlen-1:0] load_data,
  output logic            lsu_done
);

  logic start;

  assign start = load_start | store_start;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lsu_mem_req <= 1'b0;
      lsu_mem_we  <= 1'b0;
      lsu_done    <= 1'b0;
    end else begin
      lsu_mem_req <= start;         // Single request, one cycle after the start strobe
      lsu_done    <= lsu_mem_resp;  // Done one cycle after the response
      if (start) begin
        lsu_mem_we <= store_start;  // Held until the next access
      end
    end
  end

  // Address and data registers, read data register
  always_ff @(posedge clk) begin
    if (start) begin
      lsu_addr  <= addr;
      lsu_wdata <= store_data;
    end
    if (lsu_mem_resp && !lsu_mem_we) begin
      load_data <= mem_rdata;
    end
  end

endmodule

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter import rv_core_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            fetch_mem_req,
  input  logic [xlen-1:0] fetch_addr,
  input  logic            lsu_mem_req,
  input  logic            lsu_mem_we,
  input  logic [xlen-1:0] lsu_addr,
  input  logic [xlen-1:0] lsu_wdata,
  output logic            mem_req,
  output logic            mem_we,
  output logic [xlen-1:0] mem_addr,
  output logic [xlen-1:0] mem_wdata,
  input  logic            mem_resp,
  output logic            fetch_mem_resp,
  output logic            lsu_mem_resp
);

  logic pending;    // Access on the port, no response yet
  logic owner_lsu;  // Who gets the response

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_req   <= 1'b0;
      mem_we    <= 1'b0;
      pending   <= 1'b0;
      owner_lsu <= 1'b0;
    end else begin
      mem_req <= fetch_mem_req | lsu_mem_req;
      mem_we  <= lsu_mem_req & lsu_mem_we;  // Fetches are always reads
      if (fetch_mem_req || lsu_mem_req) begin
        pending   <= 1'b1;
        owner_lsu <= lsu_mem_req;  // Load/store wins a tie
      end else if (mem_resp) begin
        pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lsu_mem_req) begin
      mem_addr  <= lsu_addr;
      mem_wdata <= lsu_wdata;
    end else if (fetch_mem_req) begin
      mem_addr <= fetch_addr;
    end
  end

  // Response steered in the same cycle
  assign fetch_mem_resp = mem_resp & pending & ~owner_lsu;
  assign lsu_mem_resp   = mem_resp & pending & owner_lsu;

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import rv_core_pkg::*; (
  input  logic                  clk,
  input  logic [reg_addr_w-1:0] rs1,
  input  logic [reg_addr_w-1:0] rs2,
  input  logic [reg_addr_w-1:0] rd,
  input  logic                  we,
  input  logic [xlen-1:0]       wdata,
  output logic [xlen-1:0]       rs1_val,
  output logic [xlen-1:0]       rs2_val
);

  logic [xlen-1:0] regs [1:31];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (we && rd != '0) begin
      regs[rd] <= wdata;  // Writes to x0 dropped
    end
  end

  assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== rtl/rv_core_pkg.sv ====
package rv_core_pkg;

  localparam int xlen       = 32;  // Data and address width
  localparam int reg_addr_w = 5;   // Register index width

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_fence  = 7'b0001111,  // Not executed, halts
    op_system = 7'b1110011   // Not executed, also the code for unknown opcodes
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b  // LUI passes the immediate straight through
  } alu_op_e;

  // ALU first operand
  typedef enum logic [1:0] {
    a_rs1,
    a_pc,
    a_four  // Constant 4, second operand becomes the PC
  } op_a_sel_e;

  typedef enum logic {b_rs2, b_imm} op_b_sel_e;
  typedef enum logic {wb_alu, wb_load} wb_sel_e;

  // Branch conditions in funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

endpackage

// ==== rtl/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top import rv_core_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = 32'h0000_0000  // First fetch address, word aligned
) (
  input  logic            clk,
  input  logic            rst_n,
  output logic            mem_req,
  output logic            mem_we,
  output logic [xlen-1:0] mem_addr,
  output logic [xlen-1:0] mem_wdata,
  input  logic [xlen-1:0] mem_rdata,
  input  logic            mem_resp,
  output logic            halt,
  output logic [xlen-1:0] halt_pc
);

  // Control to datapath
  opcode_e   opcode;
  alu_op_e   alu_op;
  op_a_sel_e op_a_sel;
  op_b_sel_e op_b_sel;
  wb_sel_e   wb_sel;
  logic [2:0] funct3;
  logic funct7_alt, branch_taken, reg_we, pc_we;
  logic fetch_start, fetch_done, load_start, store_start, lsu_done;

  // Datapath
  logic [reg_addr_w-1:0] rd, rs1, rs2;
  logic [xlen-1:0] instr, imm, rs1_val, rs2_val, pc, alu_result, wb_data, load_data;

  // Peer requests into the arbiter
  logic            fetch_mem_req, fetch_mem_resp, lsu_mem_req, lsu_mem_we, lsu_mem_resp;
  logic [xlen-1:0] fetch_addr, lsu_addr, lsu_wdata;

  assign halt_pc = pc;  // PC is frozen on the bad instruction once halted

  control_fsm u_control_fsm (
    .clk, .rst_n, .opcode, .funct3, .funct7_alt, .branch_taken,
    .fetch_done, .lsu_done, .fetch_start, .load_start, .store_start,
    .alu_op, .op_a_sel, .op_b_sel, .wb_sel, .reg_we, .pc_we, .halt
  );

  instr_decoder u_instr_decoder (
    .instr, .opcode, .rd, .rs1, .rs2, .funct3, .funct7_alt, .imm
  );

  exec_unit #(.reset_pc(reset_pc)) u_exec_unit (
    .clk, .rst_n, .rs1_val, .rs2_val, .imm, .funct3,
    .alu_op, .op_a_sel, .op_b_sel, .wb_sel, .pc_we, .load_data,
    .pc, .alu_result, .wb_data, .branch_taken
  );

  reg_file u_reg_file (
    .clk, .rs1, .rs2, .rd, .we(reg_we), .wdata(wb_data), .rs1_val, .rs2_val
  );

  fetch_unit u_fetch_unit (
    .clk, .rst_n, .fetch_start, .pc, .fetch_mem_req, .fetch_addr,
    .fetch_mem_resp, .mem_rdata, .instr, .fetch_done
  );

  lsu u_lsu (
    .clk, .rst_n, .load_start, .store_start, .addr(alu_result), .store_data(rs2_val),
    .lsu_mem_req, .lsu_mem_we, .lsu_addr, .lsu_wdata,
    .lsu_mem_resp, .mem_rdata, .load_data, .lsu_done
  );

  mem_arbiter u_mem_arbiter (
    .clk, .rst_n, .fetch_mem_req, .fetch_addr,
    .lsu_mem_req, .lsu_mem_we, .lsu_addr, .lsu_wdata,
    .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_resp,
    .fetch_mem_resp, .lsu_mem_resp
  );

endmodule

// ==== tb/ref_model.svh ====
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// ALU behaviour straight from the RV32I definitions
function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  logic [31:0] r;
  case (f3)
    3'b000: r = alt ? a - b : a + b;
    3'b001: r = a << b[4:0];
    3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011: r = (a < b) ? 32'd1 : 32'd0;
    3'b100: r = a ^ b;
    3'b101: r = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110: r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

// Runs the loaded program on a copy of mem, queues every store, returns the halt PC
function automatic logic [31:0] run_reference();
  logic [31:0] rm [0:1023];
  logic [31:0] x [0:31];
  logic [31:0] pc, ins, a, b, res, nxt, ea, iimm, simm, bimm, jimm;
  logic        wr, tk;
  for (int i = 0; i < 1024; i++) rm[i] = mem[i];
  for (int i = 0; i < 32; i++) x[i] = '0;
  pc = reset_pc;
  for (int steps = 0; steps < 4096; steps++) begin
    ins  = rm[pc[11:2]];
    a    = x[ins[19:15]];
    b    = x[ins[24:20]];
    iimm = {{20{ins[31]}}, ins[31:20]};
    simm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    bimm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    jimm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    nxt  = pc + 4;
    res  = '0;
    wr   = 1'b1;
    case (ins[6:0])
      7'h37: res = {ins[31:12], 12'b0};        // LUI
      7'h17: res = pc + {ins[31:12], 12'b0};   // AUIPC
      7'h6f: begin                             // JAL
        res = pc + 4;
        nxt = pc + jimm;
      end
      7'h67: begin                             // JALR, low bit dropped
        res = pc + 4;
        nxt = (a + iimm) & ~32'd1;
      end
      7'h63: begin
        wr = 1'b0;
        case (ins[14:12])
          3'b000:  tk = (a == b);
          3'b001:  tk = (a != b);
          3'b100:  tk = ($signed(a) < $signed(b));
          3'b101:  tk = ($signed(a) >= $signed(b));
          3'b110:  tk = (a < b);
          3'b111:  tk = (a >= b);
          default: tk = 1'b0;
        endcase
        if (tk) nxt = pc + bimm;
      end
      7'h03: begin                             // LW
        ea  = a + iimm;
        res = rm[ea[11:2]];
      end
      7'h23: begin                             // SW
        wr = 1'b0;
        ea = a + simm;
        rm[ea[11:2]] = b;
        exp_addr.push_back(ea);
        exp_data.push_back(b);
      end
      7'h13: res = ref_alu(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, iimm);
      7'h33: res = ref_alu(ins[14:12], ins[30], a, b);
      default: return pc;                      // Unsupported, core halts here
    endcase
    if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = res;
    pc = nxt;
  end
  return 32'hffff_ffff;  // Program never reached a halt
endfunction

`endif

// ==== tb/tb_core.sv ====
`timescale 1ns/1ps

module tb_core;

  localparam logic [31:0] reset_pc = 32'h0000_0100;
  localparam logic [31:0] data_base = 32'h0000_0400;  // Words read by the loads
  localparam logic [31:0] st_base   = 32'h0000_0600;  // Store region

  logic        clk = 1'b0;
  logic        rst_n, mem_req, mem_we, mem_resp, halt;
  logic [31:0] mem_addr, mem_wdata, mem_rdata, halt_pc;

  logic [31:0] mem [0:1023];    // 4 KB, word indexed by addr[11:2]
  logic [31:0] exp_addr[$];
  logic [31:0] exp_data[$];
  logic [31:0] exp_halt_pc;
  logic [31:0] req_addr, req_wdata;
  logic        req_we, prog_built = 1'b0;
  int          prog_idx, prog_len, st_off, n_store, delay;

  `include "ref_model.svh"

  rv_core_top #(.reset_pc(reset_pc)) DUT (
    .clk, .rst_n, .mem_req, .mem_we, .mem_addr, .mem_wdata,
    .mem_rdata, .mem_resp, .halt, .halt_pc
  );

  always #5 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %08h actual %08h", name, exp, act);
      fail_run("value mismatch");
    end
  endtask

  // Instruction encoders
  function automatic logic [31:0] enc_r(input logic alt, input int rs2, input int rs1,
                                        input logic [2:0] f3, input int rd);
    return {1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1,
                                        input logic [2:0] f3, input int rd, input logic [6:0] op);
    return {imm, 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input int rs2, input int rs1,
                                        input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'h63};
  endfunction

  task automatic emit(input logic [31:0] word);
    mem[prog_idx] = word;
    prog_idx++;
    prog_len++;
  endtask

  task automatic emit_store(input int rs);
    logic [11:0] off;
    off = 12'(st_off);
    emit({off[11:5], 5'(rs), 5'd2, 3'b010, off[4:0], 7'h23});  // sw rs, off(x2)
    st_off += 4;
  endtask

  // Marker 1 if taken, 2 if the fall-through ran
  task automatic emit_branch(input logic [2:0] f3, input int rs1, input int rs2);
    emit(enc_i(12'd1, 0, 3'b000, 12, 7'h13));
    emit(enc_b(13'd8, rs2, rs1, f3));
    emit(enc_i(12'd2, 0, 3'b000, 12, 7'h13));
    emit_store(12);
  endtask

  task automatic build_program();
    logic [11:0] imm_neg, imm_pos;
    logic [2:0]  f3;
    for (int i = 0; i < 1024; i++) mem[i] = (i * 4) ^ 32'hc3c3_0000;  // Address-based fill
    imm_neg = 12'h800 | 12'($urandom_range(2047, 1));
    imm_pos = 12'($urandom_range(2047, 1));
    mem[data_base[11:2]]     = $urandom;
    mem[data_base[11:2] + 1] = $urandom;
    prog_idx = reset_pc[11:2];
    emit(enc_i(data_base[11:0], 0, 3'b000, 1, 7'h13));  // x1 data pointer
    emit(enc_i(st_base[11:0], 0, 3'b000, 2, 7'h13));    // x2 store pointer
    emit(enc_i(imm_neg, 0, 3'b000, 3, 7'h13));          // x3 negative
    emit(enc_i(imm_pos, 0, 3'b000, 14, 7'h13));         // x14 positive
    emit(enc_i(12'd0, 0, 3'b000, 16, 7'h13));           // x16 zero until a skipped write
    emit(enc_i(12'd0, 1, 3'b010, 4, 7'h03));            // lw x4, 0(x1)
    emit(enc_i(12'd4, 1, 3'b010, 5, 7'h03));            // lw x5, 4(x1)
    emit_store(4);
    emit_store(5);
    for (int k = 0; k < 8; k++) begin                   // Register forms
      emit(enc_r(1'b0, 4, 3, 3'(k), 6));
      emit_store(6);
    end
    emit(enc_r(1'b1, 4, 3, 3'b000, 6));                 // sub
    emit_store(6);
    emit(enc_r(1'b1, 5, 3, 3'b101, 6));                 // sra
    emit_store(6);
    for (int k = 0; k < 8; k++) begin                   // Immediate forms
      f3 = 3'(k);
      if (f3 == 3'b001 || f3 == 3'b101) begin
        emit(enc_i({7'b0, 5'($urandom)}, 3, f3, 7, 7'h13));
      end else begin
        emit(enc_i(12'($urandom), 3, f3, 7, 7'h13));
      end
      emit_store(7);
    end
    emit(enc_i({7'b0100000, 5'($urandom)}, 3, 3'b101, 7, 7'h13));  // srai
    emit_store(7);
    emit({20'($urandom), 5'd8, 7'h37});                 // lui x8
    emit_store(8);
    emit({20'($urandom), 5'd9, 7'h17});                 // auipc x9
    emit_store(9);
    emit_branch(3'b000, 3, 3);   // beq taken
    emit_branch(3'b000, 3, 14);
    emit_branch(3'b001, 3, 14);  // bne taken
    emit_branch(3'b001, 3, 3);
    emit_branch(3'b100, 3, 14);  // blt taken
    emit_branch(3'b100, 14, 3);
    emit_branch(3'b101, 14, 3);  // bge taken
    emit_branch(3'b101, 3, 14);
    emit_branch(3'b110, 14, 3);  // bltu taken
    emit_branch(3'b110, 3, 14);
    emit_branch(3'b111, 3, 14);  // bgeu taken
    emit_branch(3'b111, 14, 3);
    emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd15, 7'h6f});       // jal x15, +8
    emit(enc_i(12'd7, 0, 3'b000, 16, 7'h13));           // Skipped
    emit_store(15);
    emit({20'd0, 5'd17, 7'h17});                        // auipc x17, 0
    emit(enc_i(12'd17, 17, 3'b000, 17, 7'h13));         // Odd target, bit 0 cleared
    emit(enc_i(12'd0, 17, 3'b000, 18, 7'h67));          // jalr x18, 0(x17)
    emit(enc_i(12'd9, 0, 3'b000, 16, 7'h13));           // Skipped
    emit_store(18);
    emit_store(16);
    emit(32'hffff_ffff);                                // Invalid opcode
  endtask

  // Memory model, answers 1 to 4 cycles after each request
  initial begin
    forever begin
      @(posedge clk);
      if (rst_n && mem_req) begin
        req_addr  = mem_addr;
        req_we    = mem_we;
        req_wdata = mem_wdata;
        if (req_we) mem[req_addr[11:2]] = req_wdata;
        delay = $urandom_range(4, 1);
        repeat (delay - 1) @(posedge clk);
        @(negedge clk);
        mem_resp  = 1'b1;
        mem_rdata = mem[req_addr[11:2]];
        @(negedge clk);
        mem_resp  = 1'b0;
      end
    end
  end

  // Store stream and post-halt checks
  always @(posedge clk) begin
    if (rst_n && mem_req) begin
      if (halt) fail_run("memory request issued after halt");
      if (mem_we) begin
        if (exp_addr.size() == 0) fail_run("store issued beyond the expected stream");
        check_value($sformatf("store_addr_%0d", n_store), exp_addr.pop_front(), mem_addr);
        check_value($sformatf("store_data_%0d", n_store), exp_data.pop_front(), mem_wdata);
        n_store++;
      end
    end
  end

  initial begin
    wait (prog_built);
    repeat (10 + 40 * prog_len) @(posedge clk);
    fail_run("timeout, halt never rose");
  end

  initial begin
    rst_n     = 1'b0;
    mem_resp  = 1'b0;
    mem_rdata = '0;
    prog_len  = 0;
    st_off    = 0;
    n_store   = 0;
    void'($urandom(32'ha8530017));
    build_program();
    exp_halt_pc = run_reference();
    prog_built  = 1'b1;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    wait (halt === 1'b1);
    @(negedge clk);
    check_value("halt_pc", exp_halt_pc, halt_pc);
    repeat (20) @(posedge clk);  // Quiet period, monitor flags any request
    if (exp_addr.size() != 0) begin
      fail_run("halted before all expected stores");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule
